/* compile.f */
design/capi_pkg.sv
design/afu_pkg.sv
design/parity_gen.sv
design/tag_ram.sv
design/command_tag_table.sv
design/read_data_control.sv
design/read_data_subsystem.sv
verif/tb_read_data.sv

/* verif/read_data_stimulus.hex */
// Columns op tag sel code flags err en cu_id seed with op 0 idle 1 command 2 write 3 response
// sel is command type or half, flags is read then wed, err is parity corruption and expected read_error
1_11_1_00_0_0_1_a001_00000000
1_22_2_00_0_0_1_b002_00000000
2_11_0_00_0_0_1_0000_1234abcd
2_11_1_00_0_0_1_0000_0badf00d
2_22_0_00_0_0_1_0000_cafe0001
2_22_1_00_0_0_1_0000_cafe0002
0_00_0_00_0_0_1_0000_00000000
3_11_0_00_2_0_1_0000_00000000
3_11_0_00_0_0_1_0000_00000000
3_22_0_04_1_0_1_0000_00000000
3_22_0_00_1_0_1_0000_00000000
1_33_1_00_0_0_1_c003_00000000
2_33_0_00_0_2_1_0000_33330001
2_33_1_00_0_1_1_0000_33330002
1_44_1_00_0_0_1_d004_00000000
1_45_2_00_0_0_1_e005_00000000
2_44_0_00_0_0_1_0000_44440001
2_45_0_00_0_0_1_0000_45450001
2_44_1_00_0_0_1_0000_44440002
2_45_1_00_0_0_1_0000_45450002
3_33_0_03_2_0_1_0000_00000000
0_00_0_00_0_0_1_0000_00000000
3_44_0_00_2_0_1_0000_00000000
3_45_0_00_1_0_1_0000_00000000
0_00_0_00_0_0_0_0000_00000000
2_11_0_00_0_3_0_0000_deadbeef
3_11_0_00_2_0_1_0000_00000000
0_00_0_00_0_0_1_0000_00000000
3_11_0_00_2_0_1_0000_00000000

/* verif/tb_read_data.sv */
// Self-checking testbench for the read-data subsystem, run from the stimulus records file

`timescale 1ns/1ns

module tb_read_data
  import capi_pkg::*;
  import afu_pkg::*;
();

  localparam int    max_records   = 64;
  localparam int    max_cycles    = max_records + 8;
  localparam int    drain_cycles  = 6;
  localparam string stimulus_path = "verif/read_data_stimulus.hex";

  logic                   clock;
  logic                   rstn;
  logic                   enabled_in;
  logic                   cmd_valid;
  tag_t                   cmd_tag;
  cmd_type_t              cmd_type;
  logic [cu_id_width-1:0] cmd_cu_id;
  logic                   write_valid;
  tag_t                   write_tag;
  logic                   write_tag_parity;
  logic                   write_half;
  logic [half_width-1:0]  write_data;
  logic [dw_count-1:0]    write_parity;
  logic                   response_valid;
  tag_t                   response_tag;
  response_code_t         response_code;
  logic                   response_read;
  logic                   response_wed;
  logic [1:0]             read_error;
  logic                   out_valid_0;
  logic                   out_read_0;
  logic                   out_wed_0;
  tag_t                   out_tag_0;
  logic [cu_id_width-1:0] out_cu_id_0;
  logic [half_width-1:0]  out_data_0;
  logic                   out_valid_1;
  logic                   out_read_1;
  logic                   out_wed_1;
  tag_t                   out_tag_1;
  logic [cu_id_width-1:0] out_cu_id_1;
  logic [half_width-1:0]  out_data_1;

  // Record columns op tag sel code flags err en cu_id seed
  logic [83:0] records [max_records];
  int          n_rec = 0;
  int          cycle = 0;
  logic        prev_en;

  // Reference model of the command table and the stored halves
  logic                   cmd_known  [tag_count];
  cmd_type_t              cmd_kind   [tag_count];
  logic [cu_id_width-1:0] cmd_id     [tag_count];
  logic                   model_read [2][tag_count];
  logic                   model_wed  [2][tag_count];
  logic [cu_id_width-1:0] model_cu   [2][tag_count];
  logic [half_width-1:0]  model_data [2][tag_count];

  // Expected outputs per cycle, index 0 is the first edge after reset
  logic [1:0]             exp_err   [max_cycles];
  logic                   exp_valid [2][max_cycles];
  logic                   exp_read  [2][max_cycles];
  logic                   exp_wed   [2][max_cycles];
  tag_t                   exp_tag   [2][max_cycles];
  logic [cu_id_width-1:0] exp_cu    [2][max_cycles];
  logic [half_width-1:0]  exp_data  [2][max_cycles];

  read_data_subsystem uut (.*);

  always #5 clock = ~clock;

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // 16 words of 32 bits fill one half line
  function automatic logic [half_width-1:0] expand_seed(input logic [31:0] seed);
    logic [half_width-1:0] d;
    logic [31:0]           s;
    s = seed ^ 32'h5b5e_9c79;
    if (s == 32'h0) begin
      s = 32'h5b5e_9c79;
    end
    for (int k = 0; k < half_width / 32; k++) begin
      s = xorshift(s);
      d[k*32 +: 32] = s;
    end
    return d;
  endfunction

  // Odd parity, one bit per double word
  function automatic logic [dw_count-1:0] odd_data_parity(input logic [half_width-1:0] d);
    logic [dw_count-1:0] p;
    for (int g = 0; g < dw_count; g++) begin
      p[g] = ~(^d[g*(half_width/dw_count) +: half_width/dw_count]);
    end
    return p;
  endfunction

  ////////////////////////////////////////////////////////////
  // Failure reporting and comparison
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [half_width-1:0] expected,
                             input logic [half_width-1:0] got);
    if (got !== expected) begin
      abort_run($sformatf("Mismatch %s expected %0h got %0h at cycle %0d",
                          name, expected, got, cycle));
    end
  endtask

  task automatic check_outputs(input int j);
    check_value("read_error", exp_err[j], read_error);
    check_value("out_valid_0", exp_valid[0][j], out_valid_0);
    check_value("out_read_0", exp_read[0][j], out_read_0);
    check_value("out_wed_0", exp_wed[0][j], out_wed_0);
    check_value("out_valid_1", exp_valid[1][j], out_valid_1);
    check_value("out_read_1", exp_read[1][j], out_read_1);
    check_value("out_wed_1", exp_wed[1][j], out_wed_1);
    // Payload only means something while valid
    if (exp_valid[0][j]) begin
      check_value("out_tag_0", exp_tag[0][j], out_tag_0);
      check_value("out_cu_id_0", exp_cu[0][j], out_cu_id_0);
      check_value("out_data_0", exp_data[0][j], out_data_0);
    end
    if (exp_valid[1][j]) begin
      check_value("out_tag_1", exp_tag[1][j], out_tag_1);
      check_value("out_cu_id_1", exp_cu[1][j], out_cu_id_1);
      check_value("out_data_1", exp_data[1][j], out_data_1);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Record decode, drive and model update
  ////////////////////////////////////////////////////////////

  // Half h of a released line appears i + 2 + h cycles after record i is driven
  task automatic schedule_release(input int i, input tag_t tag);
    for (int h = 0; h < 2; h++) begin
      exp_valid[h][i+2+h] = 1'b1;
      exp_read[h][i+2+h]  = model_read[h][tag];
      exp_wed[h][i+2+h]   = model_wed[h][tag];
      exp_tag[h][i+2+h]   = tag;
      exp_cu[h][i+2+h]    = model_cu[h][tag];
      exp_data[h][i+2+h]  = model_data[h][tag];
    end
  endtask

  task automatic apply_record(input int i);
    logic [83:0]           r;
    tag_t                  tag;
    logic [3:0]            sel;
    logic [7:0]            code;
    logic [3:0]            err;
    logic                  eff;
    logic [half_width-1:0] d;
    logic [dw_count-1:0]   p;
    r = records[i];
    tag = r[79:72];
    sel = r[71:68];
    code = r[67:60];
    err = r[55:52];
    // The enable is registered once, so it acts one record later
    eff = prev_en;
    prev_en = r[48];
    enabled_in = r[48];
    cmd_valid = 1'b0;
    write_valid = 1'b0;
    response_valid = 1'b0;
    case (r[83:80])
      4'h1: begin
        cmd_valid = 1'b1;
        cmd_tag = tag;
        cmd_type = cmd_type_t'(sel[1:0]);
        cmd_cu_id = r[47:32];
        cmd_known[tag] = 1'b1;
        cmd_kind[tag] = cmd_type_t'(sel[1:0]);
        cmd_id[tag] = r[47:32];
      end
      4'h2: begin
        d = expand_seed(r[31:0]);
        p = odd_data_parity(d);
        // Corruption flips one double word parity bit picked by the seed
        p[r[2:0]] = p[r[2:0]] ^ err[0];
        write_valid = 1'b1;
        write_tag = tag;
        write_half = sel[0];
        write_data = d;
        write_parity = p;
        write_tag_parity = ~(^tag) ^ err[1];
        if (eff) begin
          model_read[sel[0]][tag] = cmd_known[tag] && (cmd_kind[tag] == cmd_read);
          model_wed[sel[0]][tag] = cmd_known[tag] && (cmd_kind[tag] == cmd_wed);
          model_cu[sel[0]][tag] = cmd_known[tag] ? cmd_id[tag] : '0;
          model_data[sel[0]][tag] = d;
          exp_err[i+3] = err[1:0];
        end
      end
      4'h3: begin
        response_valid = 1'b1;
        response_tag = tag;
        response_code = response_code_t'(code);
        response_read = r[57];
        response_wed = r[56];
        if (eff && (r[57] || r[56]) && (response_code_t'(code) != nlock)) begin
          schedule_release(i, tag);
        end
      end
      default: begin
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    clock = 1'b0;
    rstn = 1'b0;
    enabled_in = 1'b1;
    prev_en = 1'b1;
    cmd_valid = 1'b0;
    cmd_tag = '0;
    cmd_type = cmd_read;
    cmd_cu_id = '0;
    write_valid = 1'b0;
    write_tag = '0;
    write_tag_parity = 1'b0;
    write_half = 1'b0;
    write_data = '0;
    write_parity = '0;
    response_valid = 1'b0;
    response_tag = '0;
    response_code = done;
    response_read = 1'b0;
    response_wed = 1'b0;
    // Op f marks the end of the records
    for (int k = 0; k < max_records; k++) begin
      records[k] = '1;
    end
    $readmemh(stimulus_path, records);
    while (n_rec < max_records && records[n_rec][83:80] != 4'hf) begin
      n_rec++;
    end
    if (n_rec == 0) begin
      abort_run("Stimulus file holds no records");
    end
    for (int t = 0; t < tag_count; t++) begin
      cmd_known[t] = 1'b0;
    end
    for (int c = 0; c < max_cycles; c++) begin
      exp_err[c] = 2'b00;
      for (int h = 0; h < 2; h++) begin
        exp_valid[h][c] = 1'b0;
        exp_read[h][c] = 1'b0;
        exp_wed[h][c] = 1'b0;
      end
    end
    repeat (8) @(posedge clock);
    #1;
    check_outputs(0);
    rstn = 1'b1;
    @(posedge clock);
    for (int i = 0; i < n_rec + drain_cycles; i++) begin
      @(posedge clock);
      #1;
      cycle = i;
      check_outputs(i);
      if (i < n_rec) begin
        apply_record(i);
      end else begin
        cmd_valid = 1'b0;
        write_valid = 1'b0;
        response_valid = 1'b0;
      end
    end
    $display("RESULT: PASS");
    $finish;
  end

  // Watchdog sized from the record count
  initial begin
    wait (n_rec > 0);
    #((n_rec + 50) * 10);
    abort_run("Watchdog expired before the stimulus records completed");
  end

endmodule

/* design/read_data_subsystem.sv */
// Read-data path top level, joining the command tag table and the read data control

`timescale 1ns/1ns

module read_data_subsystem
  import capi_pkg::*;
  import afu_pkg::*;
(
  input  logic                   clock,
  input  logic                   rstn,
  input  logic                   enabled_in,
  input  logic                   cmd_valid,
  input  tag_t                   cmd_tag,
  input  cmd_type_t              cmd_type,
  input  logic [cu_id_width-1:0] cmd_cu_id,
  input  logic                   write_valid,
  input  tag_t                   write_tag,
  input  logic                   write_tag_parity,
  input  logic                   write_half,
  input  logic [half_width-1:0]  write_data,
  input  logic [dw_count-1:0]    write_parity,
  input  logic                   response_valid,
  input  tag_t                   response_tag,
  input  response_code_t         response_code,
  input  logic                   response_read,
  input  logic                   response_wed,
  output logic [1:0]             read_error,
  output logic                   out_valid_0,
  output logic                   out_read_0,
  output logic                   out_wed_0,
  output tag_t                   out_tag_0,
  output logic [cu_id_width-1:0] out_cu_id_0,
  output logic [half_width-1:0]  out_data_0,
  output logic                   out_valid_1,
  output logic                   out_read_1,
  output logic                   out_wed_1,
  output tag_t                   out_tag_1,
  output logic [cu_id_width-1:0] out_cu_id_1,
  output logic [half_width-1:0]  out_data_1
);

  tag_t        lookup_tag;
  cmd_record_t lookup_record;

  command_tag_table u_command_tag_table (
    .clock        (clock),
    .rstn         (rstn),
    .cmd_valid    (cmd_valid),
    .cmd_tag      (cmd_tag),
    .cmd_type     (cmd_type),
    .cmd_cu_id    (cmd_cu_id),
    .lookup_tag   (lookup_tag),
    .lookup_record(lookup_record)
  );

  read_data_control u_read_data_control (
    .clock           (clock),
    .rstn            (rstn),
    .enabled_in      (enabled_in),
    .write_valid     (write_valid),
    .write_tag       (write_tag),
    .write_tag_parity(write_tag_parity),
    .write_half      (write_half),
    .write_data      (write_data),
    .write_parity    (write_parity),
    .lookup_tag      (lookup_tag),
    .lookup_record   (lookup_record),
    .response_valid  (response_valid),
    .response_tag    (response_tag),
    .response_code   (response_code),
    .response_read   (response_read),
    .response_wed    (response_wed),
    .read_error      (read_error),
    .out_valid_0     (out_valid_0),
    .out_read_0      (out_read_0),
    .out_wed_0       (out_wed_0),
    .out_tag_0       (out_tag_0),
    .out_cu_id_0     (out_cu_id_0),
    .out_data_0      (out_data_0),
    .out_valid_1     (out_valid_1),
    .out_read_1      (out_read_1),
    .out_wed_1       (out_wed_1),
    .out_tag_1       (out_tag_1),
    .out_cu_id_1     (out_cu_id_1),
    .out_data_1      (out_data_1)
  );

endmodule

/* design/read_data_control.sv */
// Buffer write capture, parity check and per-tag half-line release on link responses

`timescale 1ns/1ns

module read_data_control
  import capi_pkg::*;
  import afu_pkg::*;
(
  input  logic                   clock,
  input  logic                   rstn,
  input  logic                   enabled_in,
  input  logic                   write_valid,
  input  tag_t                   write_tag,
  input  logic                   write_tag_parity,
  input  logic                   write_half,
  input  logic [half_width-1:0]  write_data,
  input  logic [dw_count-1:0]    write_parity,
  output tag_t                   lookup_tag,
  input  cmd_record_t            lookup_record,
  input  logic                   response_valid,
  input  tag_t                   response_tag,
  input  response_code_t         response_code,
  input  logic                   response_read,
  input  logic                   response_wed,
  output logic [1:0]             read_error,
  output logic                   out_valid_0,
  output logic                   out_read_0,
  output logic                   out_wed_0,
  output tag_t                   out_tag_0,
  output logic [cu_id_width-1:0] out_cu_id_0,
  output logic [half_width-1:0]  out_data_0,
  output logic                   out_valid_1,
  output logic                   out_read_1,
  output logic                   out_wed_1,
  output tag_t                   out_tag_1,
  output logic [cu_id_width-1:0] out_cu_id_1,
  output logic [half_width-1:0]  out_data_1
);

  logic                  enabled;
  logic                  write_valid_q;
  tag_t                  write_tag_q;
  logic                  write_tag_parity_q;
  logic                  write_half_q;
  logic [half_width-1:0] write_data_q;
  logic [dw_count-1:0]   write_parity_q;
  logic                  tag_parity_calc;
  logic [dw_count-1:0]   data_parity_calc;
  logic                  tag_error;
  logic                  data_error;
  logic                  we_0;
  logic                  we_1;
  half_entry_t           entry_q;
  half_entry_t           ram_out_0;
  half_entry_t           ram_out_1;
  logic                  release_q;
  logic                  hold_valid_1;
  half_entry_t           hold_1;

  // Lookup runs in parallel with the input latch
  assign lookup_tag = write_tag;

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      enabled <= 1'b0;
    end else begin
      enabled <= enabled_in;
    end
  end

  ////////////////////////////////////////////////////////////
  // Input latch and response qualify (edge W / R)
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      write_valid_q <= 1'b0;
      release_q     <= 1'b0;
    end else begin
      write_valid_q <= enabled && write_valid;
      // nlock responses and responses for other command kinds keep the data
      release_q     <= enabled && response_valid && (response_read || response_wed) &&
                       (response_code != nlock);
    end
  end

  always_ff @(posedge clock) begin
    write_tag_q        <= write_tag;
    write_tag_parity_q <= write_tag_parity;
    write_half_q       <= write_half;
    write_data_q       <= write_data;
    write_parity_q     <= write_parity;
  end

  ////////////////////////////////////////////////////////////
  // Entry build and half steering (edge W+2)
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      we_0 <= 1'b0;
      we_1 <= 1'b0;
    end else begin
      we_0 <= write_valid_q && !write_half_q;
      we_1 <= write_valid_q && write_half_q;
    end
  end

  // Shared by both RAMs since only one write enable fires
  always_ff @(posedge clock) begin
    entry_q.read_mark <= (lookup_record.cmd_type == cmd_read);
    entry_q.wed_mark  <= (lookup_record.cmd_type == cmd_wed);
    entry_q.record    <= lookup_record;
    entry_q.tag       <= write_tag_q;
    entry_q.data      <= write_data_q;
  end

  ////////////////////////////////////////////////////////////
  // Parity check
  ////////////////////////////////////////////////////////////

  parity_gen #(.groups(1), .group_bits(tag_width)) u_tag_parity (
    .data(write_tag_q),
    .odd (parity_odd),
    .par (tag_parity_calc)
  );

  parity_gen #(.groups(dw_count), .group_bits(half_width / dw_count)) u_data_parity (
    .data(write_data_q),
    .odd (parity_odd),
    .par (data_parity_calc)
  );

  // Compare at W+2 and flags out after W+3
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      tag_error  <= 1'b0;
      data_error <= 1'b0;
      read_error <= 2'b00;
    end else begin
      tag_error  <= write_valid_q && (tag_parity_calc != write_tag_parity_q);
      data_error <= write_valid_q && |(data_parity_calc ^ write_parity_q);
      read_error <= {tag_error, data_error};
    end
  end

  ////////////////////////////////////////////////////////////
  // Half-line storage read at the response tag
  ////////////////////////////////////////////////////////////

  tag_ram #(.entry_t(half_entry_t)) u_half_ram_0 (
    .clock   (clock),
    .we      (we_0),
    .wr_addr (entry_q.tag),
    .data_in (entry_q),
    .rd_addr (response_tag),
    .data_out(ram_out_0)
  );

  tag_ram #(.entry_t(half_entry_t)) u_half_ram_1 (
    .clock   (clock),
    .we      (we_1),
    .wr_addr (entry_q.tag),
    .data_in (entry_q),
    .rd_addr (response_tag),
    .data_out(ram_out_1)
  );

  ////////////////////////////////////////////////////////////
  // Release of half 0 at R+1 and half 1 at R+2
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      out_valid_0  <= 1'b0;
      out_read_0   <= 1'b0;
      out_wed_0    <= 1'b0;
      hold_valid_1 <= 1'b0;
      out_valid_1  <= 1'b0;
      out_read_1   <= 1'b0;
      out_wed_1    <= 1'b0;
    end else begin
      out_valid_0  <= release_q;
      out_read_0   <= release_q && ram_out_0.read_mark;
      out_wed_0    <= release_q && ram_out_0.wed_mark;
      hold_valid_1 <= release_q;
      out_valid_1  <= hold_valid_1;
      out_read_1   <= hold_valid_1 && hold_1.read_mark;
      out_wed_1    <= hold_valid_1 && hold_1.wed_mark;
    end
  end

  always_ff @(posedge clock) begin
    out_tag_0   <= ram_out_0.tag;
    out_cu_id_0 <= ram_out_0.record.cu_id;
    out_data_0  <= ram_out_0.data;
    hold_1      <= ram_out_1;
    out_tag_1   <= hold_1.tag;
    out_cu_id_1 <= hold_1.record.cu_id;
    out_data_1  <= hold_1.data;
  end

  // Half 1 belongs to the same line as the half 0 one cycle earlier
  a_half_same_tag : assert property (
    @(posedge clock) disable iff (!rstn) out_valid_1 |-> (out_tag_1 == $past(out_tag_0))
  ) else $error("half 1 tag differs from the preceding half 0");

  // Each released half comes from exactly one of a read or a WED command
  a_marks_exclusive : assert property (
    @(posedge clock) disable iff (!rstn)
      (!out_valid_0 || $onehot({out_read_0, out_wed_0})) &&
      (!out_valid_1 || $onehot({out_read_1, out_wed_1}))
  ) else $error("released half without exactly one of the read and WED marks");

endmodule

/* design/command_tag_table.sv */
// Per-tag record of issued commands, looked up by the read path on each buffer write

`timescale 1ns/1ns

module command_tag_table
  import capi_pkg::*;
  import afu_pkg::*;
(
  input  logic                   clock,
  input  logic                   rstn,
  input  logic                   cmd_valid,
  input  tag_t                   cmd_tag,
  input  cmd_type_t              cmd_type,
  input  logic [cu_id_width-1:0] cmd_cu_id,
  input  tag_t                   lookup_tag,
  output cmd_record_t            lookup_record
);

  logic [tag_count-1:0] tag_valid;
  logic                 lookup_valid;
  cmd_record_t          cmd_record;
  cmd_record_t          stored_record;

  assign cmd_record = '{cmd_type: cmd_type, cu_id: cmd_cu_id};

  ////////////////////////////////////////////////////////////
  // Valid bit per tag
  ////////////////////////////////////////////////////////////

  // Sampled alongside the RAM read so both line up one cycle later
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      tag_valid    <= '0;
      lookup_valid <= 1'b0;
    end else begin
      if (cmd_valid) begin
        tag_valid[cmd_tag] <= 1'b1;
      end
      lookup_valid <= tag_valid[lookup_tag];
    end
  end

  tag_ram #(
    .entry_t(cmd_record_t)
  ) u_record_ram (
    .clock   (clock),
    .we      (cmd_valid),
    .wr_addr (cmd_tag),
    .data_in (cmd_record),
    .rd_addr (lookup_tag),
    .data_out(stored_record)
  );

  // Unissued tags read back as no command
  always_comb begin
    if (lookup_valid) begin
      lookup_record = stored_record;
    end else begin
      lookup_record = '{cmd_type: cmd_none, cu_id: '0};
    end
  end

  // cmd_none is reserved for the empty slot
  a_cmd_has_type : assert property (
    @(posedge clock) disable iff (!rstn) cmd_valid |-> cmd_type != cmd_none
  ) else $error("command recorded with type cmd_none");

endmodule

/* design/tag_ram.sv */
// Tag-indexed storage with a registered read, shared by the command table and read path

`timescale 1ns/1ns

module tag_ram
  import capi_pkg::*;
  import afu_pkg::*;
#(
  parameter type entry_t = logic [7:0]
) (
  input  logic   clock,
  input  logic   we,
  input  tag_t   wr_addr,
  input  entry_t data_in,
  input  tag_t   rd_addr,
  output entry_t data_out
);

  entry_t mem [tag_count];

  // Read returns the old contents on a same-address write
  always_ff @(posedge clock) begin
    if (we) begin
      mem[wr_addr] <= data_in;
    end
    data_out <= mem[rd_addr];
  end

  // An unknown address would corrupt an arbitrary slot
  a_wr_addr_known : assert property (
    @(posedge clock) we |-> !$isunknown(wr_addr)
  ) else $error("tag_ram write with unknown address");

endmodule

/* design/parity_gen.sv */
// Per-group parity generator, one bit per group, odd or even by input

`timescale 1ns/1ns

module parity_gen #(
  parameter int groups     = 1,
  parameter int group_bits = 8
) (
  input  logic [groups*group_bits-1:0] data,
  input  logic                         odd,
  output logic [groups-1:0]            par
);

  ////////////////////////////////////////////////////////////
  // Reduction per group
  ////////////////////////////////////////////////////////////

  // Group 0 sits in the low bits of data
  always_comb begin
    for (int g = 0; g < groups; g++) begin
      par[g] = (^data[g*group_bits +: group_bits]) ^ odd;
    end
  end

  // Groups are whole bytes on the link
  initial begin
    if (group_bits % 8 != 0) begin
      $error("parity_gen group_bits %0d is not a byte multiple", group_bits);
    end
  end

endmodule

/* design/afu_pkg.sv */
// Accelerator-side constants and the records kept per tag on the read path

package afu_pkg;

  import capi_pkg::*;

  ////////////////////////////////////////////////////////////
  // Sizing
  ////////////////////////////////////////////////////////////

  // One RAM slot per possible tag
  localparam int tag_count = 256;

  // Identifier of the compute unit that issued a command
  localparam int cu_id_width = 16;

  ////////////////////////////////////////////////////////////
  // Command record, kept per tag at issue time
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    cmd_type_t              cmd_type;
    logic [cu_id_width-1:0] cu_id;
  } cmd_record_t;

  ////////////////////////////////////////////////////////////
  // Stored half line
  ////////////////////////////////////////////////////////////

  // Marks are mutually exclusive and come from the command type
  typedef struct packed {
    logic                  read_mark;
    logic                  wed_mark;
    cmd_record_t           record;
    tag_t                  tag;
    logic [half_width-1:0] data;
  } half_entry_t;

endpackage

/* design/capi_pkg.sv */
// Link-side definitions shared by every block that sees the processor link

package capi_pkg;

  ////////////////////////////////////////////////////////////
  // Command tags
  ////////////////////////////////////////////////////////////

  localparam int tag_width = 8;

  typedef logic [tag_width-1:0] tag_t;

  // Kinds of command the accelerator can issue
  typedef enum logic [1:0] {
    cmd_none  = 2'd0,
    cmd_read  = 2'd1,
    cmd_wed   = 2'd2,
    cmd_write = 2'd3
  } cmd_type_t;

  ////////////////////////////////////////////////////////////
  // Response codes
  ////////////////////////////////////////////////////////////

  // Encodings as returned on the link response bus
  typedef enum logic [7:0] {
    done   = 8'h00,
    aerror = 8'h01,
    derror = 8'h03,
    nlock  = 8'h04,
    nres   = 8'h05,
    failed = 8'h08,
    paged  = 8'h0a
  } response_code_t;

  ////////////////////////////////////////////////////////////
  // Buffer write data and parity
  ////////////////////////////////////////////////////////////

  // One buffer write carries half of a 1024-bit cache line
  localparam int half_width = 512;
  localparam int dw_count   = 8;

  // Link parity is odd on both tag and data
  localparam logic parity_odd = 1'b1;

endpackage
